//--- filelist.f
+incdir+.
rv_decode_pkg.sv
decode_if.sv
decode_latch.sv
instr_classifier.sv
imm_gen.sv
ctrl_gen.sv
rv_decode_top.sv
tb_clock_gen.sv
rv_decode_tb.sv

//--- rv_decode_tb.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module rv_decode_tb;
    import rv_decode_pkg::*;

    typedef struct
    {
        string          name;
        logic [31:0]    word;
        logic           stall;
        logic           flush;
        logic [31:0]    imm;
        logic [12:0]    ctrl;
        logic [4:0]     alu;
    } vec_t;

    // rw, mr, mw, res_src[1:0], op1, op2, jump, branch, pc_sel, inv, csr_rd, csr_wr
    localparam logic [12:0] C_ALUI   = 13'b1_0_0_00_0_1_0_0_0_0_0_0;
    localparam logic [12:0] C_ALUR   = 13'b1_0_0_00_0_0_0_0_0_0_0_0;
    localparam logic [12:0] C_AUIPC  = 13'b1_0_0_00_1_1_0_0_0_0_0_0;
    localparam logic [12:0] C_JAL    = 13'b1_0_0_10_1_1_1_0_0_0_0_0;
    localparam logic [12:0] C_JALR   = 13'b1_0_0_10_0_1_1_0_1_0_0_0;
    localparam logic [12:0] C_BR     = 13'b0_0_0_00_0_0_0_1_0_0_0_0;
    localparam logic [12:0] C_LOAD   = 13'b1_1_0_01_0_1_0_0_0_0_0_0;
    localparam logic [12:0] C_STORE  = 13'b0_0_1_00_0_1_0_0_0_0_0_0;
    localparam logic [12:0] C_NOP    = 13'b0_0_0_00_0_0_0_0_0_0_0_0;
    localparam logic [12:0] C_INV    = 13'b0_0_0_00_0_0_0_0_0_1_0_0;
    localparam logic [12:0] C_CSR_RW = 13'b0_0_0_00_0_0_0_0_0_1_1_1;
    localparam logic [12:0] C_CSR_R  = 13'b0_0_0_00_0_0_0_0_0_1_1_0;
    localparam logic [12:0] C_CSR_W  = 13'b0_0_0_00_0_0_0_0_0_1_0_1;

    logic                       i_clk;
    logic                       i_rst_n;
    logic                       i_stall;
    logic                       i_flush;
    logic [`XLEN-1:0]           i_data;
    logic [`XLEN-1:`PC_LSB]     i_pc;
    logic [`XLEN-1:`PC_LSB]     i_pc_p4;
    logic [`REG_IDX_W-1:0]      o_rs1;
    logic [`REG_IDX_W-1:0]      o_rs2;
    logic [`REG_IDX_W-1:0]      o_rd;
    logic [`XLEN-1:`PC_LSB]     o_pc;
    logic [`XLEN-1:`PC_LSB]     o_pc_p4;
    logic [`XLEN-1:0]           o_imm;
    logic                       o_reg_write;
    logic                       o_mem_read;
    logic                       o_mem_write;
    res_src_e                   o_res_src;
    logic                       o_pc_sel;
    logic                       o_jump;
    logic                       o_branch;
    op1_sel_e                   o_alu_op1_sel;
    op2_sel_e                   o_alu_op2_sel;
    logic [`FUNCT3_W-1:0]       o_funct3;
    logic [`ALU_CTRL_W-1:0]     o_alu_ctrl;
    logic                       o_inv_instr;
    logic [`CSR_IDX_W-1:0]      o_csr_idx;
    logic                       o_csr_read;
    logic                       o_csr_write;

    vec_t                       vecs[$];
    logic [31:0]                rnd_state;
    int                         test_bad;
    int                         pass_count;
    int                         fail_count;

    tb_clock_gen clk_gen
    (
        .o_clk      (i_clk),
        .o_rst_n    (i_rst_n)
    );

    rv_decode_top rv_decode_top_inst
    (
        .*
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // one encoder per instruction format
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] grp);
        return {f7, rs2, rs1, f3, rd, grp, `OPC_FULL};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] grp);
        return {imm, rs1, f3, rd, grp, `OPC_FULL};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] grp);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], grp, `OPC_FULL};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] grp);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], grp, `OPC_FULL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [31:0] imm, input logic [4:0] rd,
        input logic [4:0] grp);
        return {imm[31:12], rd, grp, `OPC_FULL};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd,
        input logic [4:0] grp);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, grp, `OPC_FULL};
    endfunction

    task automatic add_vec(input string name, input logic [31:0] word, input logic stall,
        input logic flush, input logic [31:0] imm, input logic [12:0] ctrl, input logic [4:0] alu);
        vec_t v;
        v.name  = name;
        v.word  = word;
        v.stall = stall;
        v.flush = flush;
        v.imm   = imm;
        v.ctrl  = ctrl;
        v.alu   = alu;
        vecs.push_back(v);
    endtask

    task automatic add_row(input string name, input logic [31:0] word, input logic [31:0] imm,
        input logic [12:0] ctrl, input logic [4:0] alu);
        add_vec(name, word, 1'b0, 1'b0, imm, ctrl, alu);
    endtask

    task automatic build_table();
        add_row("lui", enc_u(32'hfffff000, 5'd1, `OPG_LUI), 32'hfffff000, C_ALUI, ALU_ADD);
        add_row("auipc", enc_u(32'h12345000, 5'd2, `OPG_AUIPC), 32'h12345000, C_AUIPC, ALU_ADD);
        add_row("jal", enc_j(21'h1abcd0, 5'd1, `OPG_JAL), 32'hfffabcd0, C_JAL, ALU_ADD);
        add_row("jalr", enc_i(12'hff0, 5'd3, 3'd0, 5'd1, `OPG_JALR), 32'hfffffff0, C_JALR, ALU_ADD);
        add_row("beq", enc_b(13'h1ff8, 5'd2, 5'd1, 3'd0, `OPG_BRANCH), 32'hfffffff8, C_BR, ALU_EQ);
        add_row("bne", enc_b(13'h0ffe, 5'd2, 5'd1, 3'd1, `OPG_BRANCH), 32'h00000ffe, C_BR, ALU_NEQ);
        add_row("blt", enc_b(13'h1000, 5'd4, 5'd3, 3'd4, `OPG_BRANCH), 32'hfffff000, C_BR, ALU_LTS);
        add_row("bge", enc_b(13'h0010, 5'd4, 5'd3, 3'd5, `OPG_BRANCH), 32'h00000010, C_BR, ALU_NLTS);
        add_row("bltu", enc_b(13'h1802, 5'd6, 5'd5, 3'd6, `OPG_BRANCH), 32'hfffff802, C_BR, ALU_LTU);
        add_row("bgeu", enc_b(13'h0aa4, 5'd6, 5'd5, 3'd7, `OPG_BRANCH), 32'h00000aa4, C_BR, ALU_NLTU);
        add_row("lb", enc_i(12'hffc, 5'd2, 3'd0, 5'd3, `OPG_LOAD), 32'hfffffffc, C_LOAD, ALU_ADD);
        add_row("lh", enc_i(12'h800, 5'd2, 3'd1, 5'd3, `OPG_LOAD), 32'hfffff800, C_LOAD, ALU_ADD);
        add_row("lw", enc_i(12'h010, 5'd2, 3'd2, 5'd3, `OPG_LOAD), 32'h00000010, C_LOAD, ALU_ADD);
        add_row("lbu", enc_i(12'h7ff, 5'd2, 3'd4, 5'd3, `OPG_LOAD), 32'h000007ff, C_LOAD, ALU_ADD);
        add_row("lhu", enc_i(12'h123, 5'd2, 3'd5, 5'd3, `OPG_LOAD), 32'h00000123, C_LOAD, ALU_ADD);
        add_row("sb", enc_s(12'h7ff, 5'd4, 5'd2, 3'd0, `OPG_STORE), 32'h000007ff, C_STORE, ALU_ADD);
        add_row("sh", enc_s(12'h801, 5'd4, 5'd2, 3'd1, `OPG_STORE), 32'hfffff801, C_STORE, ALU_ADD);
        add_row("sw", enc_s(12'hfe0, 5'd4, 5'd2, 3'd2, `OPG_STORE), 32'hffffffe0, C_STORE, ALU_ADD);
        add_row("addi", enc_i(12'h800, 5'd1, 3'd0, 5'd2, `OPG_OP_IMM), 32'hfffff800, C_ALUI, ALU_ADD);
        add_row("slti", enc_i(12'hfff, 5'd1, 3'd2, 5'd2, `OPG_OP_IMM), 32'hffffffff, C_ALUI, ALU_LTS);
        add_row("sltiu", enc_i(12'h001, 5'd1, 3'd3, 5'd2, `OPG_OP_IMM), 32'h00000001, C_ALUI, ALU_LTU);
        add_row("xori", enc_i(12'hf0f, 5'd1, 3'd4, 5'd2, `OPG_OP_IMM), 32'hffffff0f, C_ALUI, ALU_XOR);
        add_row("ori", enc_i(12'h0f0, 5'd1, 3'd6, 5'd2, `OPG_OP_IMM), 32'h000000f0, C_ALUI, ALU_OR);
        add_row("andi", enc_i(12'h555, 5'd1, 3'd7, 5'd2, `OPG_OP_IMM), 32'h00000555, C_ALUI, ALU_AND);
        add_row("slli", enc_i(12'h003, 5'd1, 3'd1, 5'd2, `OPG_OP_IMM), 32'h00000003, C_ALUI, ALU_SHL);
        add_row("srli", enc_i(12'h01f, 5'd1, 3'd5, 5'd2, `OPG_OP_IMM), 32'h0000001f, C_ALUI, ALU_SHR);
        add_row("srai", enc_i(12'h405, 5'd1, 3'd5, 5'd2, `OPG_OP_IMM), 32'h00000405, C_ALUI,
                {1'b1, ALU_SHR});
        // new inputs while stalled, then a flush that beats the stall
        add_vec("stall", enc_u(32'habcde000, 5'd9, `OPG_LUI), 1'b1, 1'b0, 32'h00000405, C_ALUI,
                {1'b1, ALU_SHR});
        add_vec("flush", enc_j(21'h000ffe, 5'd1, `OPG_JAL), 1'b1, 1'b1, 32'h0, C_INV, ALU_ADD);
        add_row("add", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_ADD);
        add_row("sub", enc_r(`F7_ALT, 5'd2, 5'd1, 3'd0, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_SUB);
        add_row("sll", enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_SHL);
        add_row("slt", enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_LTS);
        add_row("sltu", enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_LTU);
        add_row("xor", enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_XOR);
        add_row("srl", enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_SHR);
        add_row("sra", enc_r(`F7_ALT, 5'd2, 5'd1, 3'd5, 5'd3, `OPG_OP), 32'h0, C_ALUR,
                {1'b1, ALU_SHR});
        add_row("or", enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_OR);
        add_row("and", enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd3, `OPG_OP), 32'h0, C_ALUR, ALU_AND);
        add_row("fence", enc_i(12'h0ff, 5'd0, 3'd0, 5'd0, `OPG_MISC_MEM), 32'h0, C_NOP, ALU_ADD);
        add_row("fence_i", enc_i(12'h000, 5'd0, 3'd1, 5'd0, `OPG_MISC_MEM), 32'h0, C_NOP, ALU_ADD);
        add_row("ecall", enc_i(12'h000, 5'd0, 3'd0, 5'd0, `OPG_SYSTEM), 32'h0, C_INV, ALU_ADD);
        add_row("ebreak", enc_i(12'h001, 5'd0, 3'd0, 5'd0, `OPG_SYSTEM), 32'h0, C_INV, ALU_ADD);
        add_row("compressed", 32'h00004501, 32'h0, C_INV, ALU_ADD);
        add_row("bad_f7", enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd3, `OPG_OP), 32'h0, C_INV, ALU_ADD);
        add_row("csrrw", enc_i(12'h300, 5'd1, 3'd1, 5'd5, `OPG_SYSTEM), 32'h0, C_CSR_RW, ALU_ADD);
        add_row("csrrw_x0", enc_i(12'h305, 5'd1, 3'd1, 5'd0, `OPG_SYSTEM), 32'h0, C_CSR_W, ALU_ADD);
        add_row("csrrs", enc_i(12'h341, 5'd2, 3'd2, 5'd3, `OPG_SYSTEM), 32'h0, C_CSR_RW, ALU_ADD);
        add_row("csrrs_x0", enc_i(12'hc00, 5'd0, 3'd2, 5'd3, `OPG_SYSTEM), 32'h0, C_CSR_R, ALU_ADD);
        add_row("csrrc", enc_i(12'h342, 5'd4, 3'd3, 5'd6, `OPG_SYSTEM), 32'h0, C_CSR_RW, ALU_ADD);
        add_row("csrrwi", enc_i(12'h340, 5'd7, 3'd5, 5'd1, `OPG_SYSTEM), 32'h0, C_CSR_RW, ALU_ADD);
        add_row("csrrsi_0", enc_i(12'hf14, 5'd0, 3'd6, 5'd2, `OPG_SYSTEM), 32'h0, C_CSR_R, ALU_ADD);
        add_row("csrrci", enc_i(12'h300, 5'd3, 3'd7, 5'd8, `OPG_SYSTEM), 32'h0, C_CSR_RW, ALU_ADD);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
        input logic [31:0] exp);
        $display("[FAIL] %s got 0x%08h expected 0x%08h", sig, got, exp);
        test_bad++;
    endtask

    task automatic check_outputs(input vec_t v, input logic [31:0] lw,
        input logic [`XLEN-1:`PC_LSB] pc, input logic [`XLEN-1:`PC_LSB] pc4);
        logic [4:0] rs1_exp;
        // lui reads x0
        rs1_exp = (lw[6:0] == {`OPG_LUI, `OPC_FULL}) ? 5'd0 : lw[19:15];
        if (o_imm !== v.imm) report_mismatch("o_imm", o_imm, v.imm);
        if (o_reg_write !== v.ctrl[12]) report_mismatch("o_reg_write", o_reg_write, v.ctrl[12]);
        if (o_mem_read !== v.ctrl[11]) report_mismatch("o_mem_read", o_mem_read, v.ctrl[11]);
        if (o_mem_write !== v.ctrl[10]) report_mismatch("o_mem_write", o_mem_write, v.ctrl[10]);
        if (o_res_src !== v.ctrl[9:8]) report_mismatch("o_res_src", o_res_src, v.ctrl[9:8]);
        if (o_alu_op1_sel !== v.ctrl[7]) report_mismatch("o_alu_op1_sel", o_alu_op1_sel, v.ctrl[7]);
        if (o_alu_op2_sel !== v.ctrl[6]) report_mismatch("o_alu_op2_sel", o_alu_op2_sel, v.ctrl[6]);
        if (o_jump !== v.ctrl[5]) report_mismatch("o_jump", o_jump, v.ctrl[5]);
        if (o_branch !== v.ctrl[4]) report_mismatch("o_branch", o_branch, v.ctrl[4]);
        if (o_pc_sel !== v.ctrl[3]) report_mismatch("o_pc_sel", o_pc_sel, v.ctrl[3]);
        if (o_inv_instr !== v.ctrl[2]) report_mismatch("o_inv_instr", o_inv_instr, v.ctrl[2]);
        if (o_csr_read !== v.ctrl[1]) report_mismatch("o_csr_read", o_csr_read, v.ctrl[1]);
        if (o_csr_write !== v.ctrl[0]) report_mismatch("o_csr_write", o_csr_write, v.ctrl[0]);
        if (o_alu_ctrl !== v.alu) report_mismatch("o_alu_ctrl", o_alu_ctrl, v.alu);
        if (o_pc !== pc) report_mismatch("o_pc", o_pc, pc);
        if (o_pc_p4 !== pc4) report_mismatch("o_pc_p4", o_pc_p4, pc4);
        if (o_funct3 !== lw[14:12]) report_mismatch("o_funct3", o_funct3, lw[14:12]);
        if (o_csr_idx !== lw[31:20]) report_mismatch("o_csr_idx", o_csr_idx, lw[31:20]);
        if (o_rd !== lw[11:7]) report_mismatch("o_rd", o_rd, lw[11:7]);
        if (o_rs1 !== rs1_exp) report_mismatch("o_rs1", o_rs1, rs1_exp);
        if (o_rs2 !== lw[24:20]) report_mismatch("o_rs2", o_rs2, lw[24:20]);
    endtask

    task automatic log_result(input string name);
        if (test_bad == 0)
        begin
            $display("test %s ok", name);
            pass_count++;
        end
        else
        begin
            $display("test %s failed with %0d mismatches", name, test_bad);
            fail_count++;
        end
    endtask

    task automatic check_reset();
        vec_t r;
        r.name  = "reset";
        r.word  = '0;
        r.stall = 1'b0;
        r.flush = 1'b0;
        r.imm   = '0;
        r.ctrl  = C_INV;
        r.alu   = ALU_ADD;
        test_bad = 0;
        check_outputs(r, 32'h0, '0, '0);
        log_result(r.name);
    endtask

    task automatic run_table();
        vec_t                       v;
        logic [31:0]                lat_word;
        logic [`XLEN-1:`PC_LSB]     pc_in;
        logic [`XLEN-1:`PC_LSB]     exp_pc;
        logic [`XLEN-1:`PC_LSB]     exp_pc4;
        lat_word = '0;
        exp_pc   = '0;
        exp_pc4  = '0;
        foreach (vecs[i])
        begin
            v = vecs[i];
            rnd_state = xorshift32(rnd_state);
            pc_in     = rnd_state[`XLEN-1:`PC_LSB];
            i_data    = v.word;
            i_stall   = v.stall;
            i_flush   = v.flush;
            i_pc      = pc_in;
            i_pc_p4   = pc_in + 1'b1;
            // what the stage register should hold after the next edge
            if (v.flush)
            begin
                lat_word = '0;
                exp_pc   = '0;
                exp_pc4  = '0;
            end
            else if (!v.stall)
            begin
                lat_word = v.word;
                exp_pc   = pc_in;
                exp_pc4  = pc_in + 1'b1;
            end
            @(posedge i_clk);
            @(negedge i_clk);
            test_bad = 0;
            check_outputs(v, lat_word, exp_pc, exp_pc4);
            log_result(v.name);
        end
        i_stall = 1'b0;
        i_flush = 1'b0;
    endtask

    initial
    begin
        int waited;
        i_stall    = 1'b0;
        i_flush    = 1'b0;
        i_data     = '0;
        i_pc       = '0;
        i_pc_p4    = '0;
        rnd_state  = 32'd66849;
        pass_count = 0;
        fail_count = 0;
        build_table();
        waited = 0;
        while (i_rst_n !== 1'b1 && waited < 40)
        begin
            @(negedge i_clk);
            waited++;
        end
        if (i_rst_n !== 1'b1)
        begin
            $display("timeout: reset was never released");
            $display("Errors found");
            $finish;
        end
        else
        begin
            check_reset();
            run_table();
            $display("%0d tests run, %0d passed, %0d failed",
                     pass_count + fail_count, pass_count, fail_count);
            if (fail_count == 0)
                $display("No errors");
            else
                $display("Errors found");
            $finish;
        end
    end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic o_clk,
    output logic o_rst_n
);

    // 4 ns period
    initial
    begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // held for 8 cycles, released on a falling edge
    initial
    begin
        o_rst_n = 1'b0;
        repeat (8) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

//--- rv_decode_top.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module rv_decode_top
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic [`XLEN-1:0]            i_data,
    input  logic [`XLEN-1:`PC_LSB]      i_pc,
    input  logic [`XLEN-1:`PC_LSB]      i_pc_p4,
    output logic [`REG_IDX_W-1:0]       o_rs1,
    output logic [`REG_IDX_W-1:0]       o_rs2,
    output logic [`REG_IDX_W-1:0]       o_rd,
    output logic [`XLEN-1:`PC_LSB]      o_pc,
    output logic [`XLEN-1:`PC_LSB]      o_pc_p4,
    output logic [`XLEN-1:0]            o_imm,
    output logic                        o_reg_write,
    output logic                        o_mem_read,
    output logic                        o_mem_write,
    output rv_decode_pkg::res_src_e     o_res_src,
    output logic                        o_pc_sel,
    output logic                        o_jump,
    output logic                        o_branch,
    output rv_decode_pkg::op1_sel_e     o_alu_op1_sel,
    output rv_decode_pkg::op2_sel_e     o_alu_op2_sel,
    output logic [`FUNCT3_W-1:0]        o_funct3,
    output logic [`ALU_CTRL_W-1:0]      o_alu_ctrl,
    output logic                        o_inv_instr,
    output logic [`CSR_IDX_W-1:0]       o_csr_idx,
    output logic                        o_csr_read,
    output logic                        o_csr_write
);

    decode_if dec_if ();

    decode_latch u_latch
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_flush    (i_flush),
        .i_data     (i_data),
        .i_pc       (i_pc),
        .i_pc_p4    (i_pc_p4),
        .o_pc       (o_pc),
        .o_pc_p4    (o_pc_p4),
        .dec        (dec_if)
    );

    instr_classifier u_cls
    (
        .dec        (dec_if)
    );

    imm_gen u_imm
    (
        .dec        (dec_if),
        .o_imm      (o_imm)
    );

    ctrl_gen u_ctrl
    (
        .dec            (dec_if),
        .o_reg_write    (o_reg_write),
        .o_mem_read     (o_mem_read),
        .o_mem_write    (o_mem_write),
        .o_res_src      (o_res_src),
        .o_alu_op1_sel  (o_alu_op1_sel),
        .o_alu_op2_sel  (o_alu_op2_sel),
        .o_alu_ctrl     (o_alu_ctrl),
        .o_jump         (o_jump),
        .o_branch       (o_branch),
        .o_pc_sel       (o_pc_sel),
        .o_csr_read     (o_csr_read),
        .o_csr_write    (o_csr_write),
        .o_inv_instr    (o_inv_instr)
    );

    assign o_rs1     = dec_if.rs1;
    assign o_rs2     = dec_if.rs2;
    assign o_rd      = dec_if.rd;
    // raw fields straight off the latched word
    assign o_funct3  = dec_if.instr[`F3_LSB +: `FUNCT3_W];
    assign o_csr_idx = dec_if.instr[`F12_LSB +: `CSR_IDX_W];

endmodule

//--- ctrl_gen.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module ctrl_gen
(
    decode_if.user                      dec,
    output logic                        o_reg_write,
    output logic                        o_mem_read,
    output logic                        o_mem_write,
    output rv_decode_pkg::res_src_e     o_res_src,
    output rv_decode_pkg::op1_sel_e     o_alu_op1_sel,
    output rv_decode_pkg::op2_sel_e     o_alu_op2_sel,
    output logic [`ALU_CTRL_W-1:0]      o_alu_ctrl,
    output logic                        o_jump,
    output logic                        o_branch,
    output logic                        o_pc_sel,
    output logic                        o_csr_read,
    output logic                        o_csr_write,
    output logic                        o_inv_instr
);
    import rv_decode_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       is_imm;
    logic       is_reg;
    logic       is_branch;
    logic       is_jump;
    logic       is_upper;
    logic       shift_arith;
    logic       csr_rw;
    logic       csr_set_clr;
    alu_ctrl_e  alu_op;

    // instruction groups
    assign is_load   = dec.op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign is_store  = dec.op inside {OP_SB, OP_SH, OP_SW};
    assign is_imm    = dec.op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
                                      OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI};
    assign is_reg    = dec.op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                                      OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
    assign is_branch = dec.op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    assign is_jump   = dec.op inside {OP_JAL, OP_JALR};
    assign is_upper  = dec.op inside {OP_LUI, OP_AUIPC};

    assign o_reg_write = is_load | is_imm | is_reg | is_jump | is_upper;
    assign o_mem_read  = is_load;
    assign o_mem_write = is_store;
    assign o_jump      = is_jump;
    assign o_branch    = is_branch;
    // jalr target comes from the ALU, not the PC adder
    assign o_pc_sel    = (dec.op == OP_JALR);

    always_comb
    begin
        if (dec.op inside {OP_AUIPC, OP_JAL})
            o_alu_op1_sel = OP1_PC;
        else
            o_alu_op1_sel = OP1_REG;

        if (is_upper | is_jump | is_imm | is_load | is_store)
            o_alu_op2_sel = OP2_IMM;
        else
            o_alu_op2_sel = OP2_REG;

        if (is_load)
            o_res_src = RES_MEM;
        else if (is_jump)
            o_res_src = RES_PC_P4;
        else
            o_res_src = RES_ALU;
    end

    always_comb
    begin
        case (dec.op)
        OP_BEQ:                     alu_op = ALU_EQ;
        OP_BNE:                     alu_op = ALU_NEQ;
        OP_SLTI, OP_SLT, OP_BLT:    alu_op = ALU_LTS;
        OP_SLTIU, OP_SLTU, OP_BLTU: alu_op = ALU_LTU;
        OP_BGE:                     alu_op = ALU_NLTS;
        OP_BGEU:                    alu_op = ALU_NLTU;
        OP_SUB:                     alu_op = ALU_SUB;
        OP_XORI, OP_XOR:            alu_op = ALU_XOR;
        OP_ORI, OP_OR:              alu_op = ALU_OR;
        OP_ANDI, OP_AND:            alu_op = ALU_AND;
        OP_SLLI, OP_SLL:            alu_op = ALU_SHL;
        OP_SRLI, OP_SRL,
        OP_SRAI, OP_SRA:            alu_op = ALU_SHR;
        default:                    alu_op = ALU_ADD;
        endcase
    end

    // top bit picks arithmetic right shift
    assign shift_arith = dec.op inside {OP_SRAI, OP_SRA};
    assign o_alu_ctrl  = {shift_arith, alu_op};

    assign csr_rw      = dec.op inside {OP_CSRRW, OP_CSRRWI};
    assign csr_set_clr = dec.op inside {OP_CSRRS, OP_CSRRC, OP_CSRRSI, OP_CSRRCI};

    // no read for a write into x0, no write for a zero mask
    assign o_csr_read  = (csr_rw & (|dec.rd)) | csr_set_clr;
    assign o_csr_write = csr_rw | (csr_set_clr & (|dec.rs1));

    // system ops decode but are not executed here
    assign o_inv_instr = (dec.op inside {OP_INVALID, OP_ECALL, OP_EBREAK})
                         | csr_rw | csr_set_clr;

endmodule

//--- imm_gen.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module imm_gen
(
    decode_if.user              dec,
    output logic [`XLEN-1:0]    o_imm
);
    import rv_decode_pkg::*;

    logic [`XLEN-1:0] w;

    assign w = dec.instr;

    always_comb
    begin
        case (dec.op)
        // J format
        OP_JAL:
            o_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        // U format
        OP_LUI, OP_AUIPC:
            o_imm = {w[31:12], 12'b0};
        // I format with funct7 left in the upper bits of a shift
        OP_JALR,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI:
            o_imm = {{21{w[31]}}, w[30:20]};
        // B format
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
            o_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        // S format
        OP_SB, OP_SH, OP_SW:
            o_imm = {{21{w[31]}}, w[30:25], w[11:7]};
        default:
            o_imm = '0;
        endcase
    end

endmodule

//--- instr_classifier.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module instr_classifier
(
    decode_if.cls   dec
);
    import rv_decode_pkg::*;

    logic                   full;
    logic [`OPG_W-1:0]      grp;
    logic [`FUNCT3_W-1:0]   f3;
    logic [`FUNCT7_W-1:0]   f7;
    logic [`CSR_IDX_W-1:0]  f12;
    instr_op_e              op_c;

    assign full = (dec.instr[1:0] == `OPC_FULL);
    assign grp  = dec.instr[`OPG_LSB +: `OPG_W];
    assign f3   = dec.instr[`F3_LSB +: `FUNCT3_W];
    assign f7   = dec.instr[`F7_LSB +: `FUNCT7_W];
    assign f12  = dec.instr[`F12_LSB +: `CSR_IDX_W];

    always_comb
    begin
        op_c = OP_INVALID;
        // compressed words never match
        if (full)
        begin
            case (grp)
            `OPG_LUI:    op_c = OP_LUI;
            `OPG_AUIPC:  op_c = OP_AUIPC;
            `OPG_JAL:    op_c = OP_JAL;
            `OPG_JALR:   op_c = (f3 == 3'b000) ? OP_JALR : OP_INVALID;
            `OPG_BRANCH:
                case (f3)
                3'b000:  op_c = OP_BEQ;
                3'b001:  op_c = OP_BNE;
                3'b100:  op_c = OP_BLT;
                3'b101:  op_c = OP_BGE;
                3'b110:  op_c = OP_BLTU;
                3'b111:  op_c = OP_BGEU;
                default: op_c = OP_INVALID;
                endcase
            `OPG_LOAD:
                case (f3)
                3'b000:  op_c = OP_LB;
                3'b001:  op_c = OP_LH;
                3'b010:  op_c = OP_LW;
                3'b100:  op_c = OP_LBU;
                3'b101:  op_c = OP_LHU;
                default: op_c = OP_INVALID;
                endcase
            `OPG_STORE:
                case (f3)
                3'b000:  op_c = OP_SB;
                3'b001:  op_c = OP_SH;
                3'b010:  op_c = OP_SW;
                default: op_c = OP_INVALID;
                endcase
            `OPG_OP_IMM:
                case (f3)
                3'b000:  op_c = OP_ADDI;
                3'b001:  op_c = OP_SLLI;
                3'b010:  op_c = OP_SLTI;
                3'b011:  op_c = OP_SLTIU;
                3'b100:  op_c = OP_XORI;
                3'b110:  op_c = OP_ORI;
                3'b111:  op_c = OP_ANDI;
                default:
                begin
                    // right shifts split on funct7
                    if (f7 == '0)
                        op_c = OP_SRLI;
                    else if (f7 == `F7_ALT)
                        op_c = OP_SRAI;
                end
                endcase
            `OPG_OP:
                case ({f7, f3})
                {7'b0000000, 3'b000}: op_c = OP_ADD;
                {`F7_ALT,    3'b000}: op_c = OP_SUB;
                {7'b0000000, 3'b001}: op_c = OP_SLL;
                {7'b0000000, 3'b010}: op_c = OP_SLT;
                {7'b0000000, 3'b011}: op_c = OP_SLTU;
                {7'b0000000, 3'b100}: op_c = OP_XOR;
                {7'b0000000, 3'b101}: op_c = OP_SRL;
                {`F7_ALT,    3'b101}: op_c = OP_SRA;
                {7'b0000000, 3'b110}: op_c = OP_OR;
                {7'b0000000, 3'b111}: op_c = OP_AND;
                default:              op_c = OP_INVALID;
                endcase
            `OPG_MISC_MEM:
                case (f3)
                3'b000:  op_c = OP_FENCE;
                3'b001:  op_c = OP_FENCE_I;
                default: op_c = OP_INVALID;
                endcase
            `OPG_SYSTEM:
                case (f3)
                3'b000:
                begin
                    if (f12 == 12'h000)
                        op_c = OP_ECALL;
                    else if (f12 == 12'h001)
                        op_c = OP_EBREAK;
                end
                3'b001:  op_c = OP_CSRRW;
                3'b010:  op_c = OP_CSRRS;
                3'b011:  op_c = OP_CSRRC;
                3'b101:  op_c = OP_CSRRWI;
                3'b110:  op_c = OP_CSRRSI;
                3'b111:  op_c = OP_CSRRCI;
                default: op_c = OP_INVALID;
                endcase
            default:     op_c = OP_INVALID;
            endcase
        end
    end

    assign dec.op  = op_c;
    assign dec.rd  = dec.instr[`RD_LSB +: `REG_IDX_W];
    // lui adds its immediate to x0
    assign dec.rs1 = (op_c == OP_LUI) ? '0 : dec.instr[`RS1_LSB +: `REG_IDX_W];
    assign dec.rs2 = dec.instr[`RS2_LSB +: `REG_IDX_W];

endmodule

//--- decode_latch.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module decode_latch
(
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic [`XLEN-1:0]            i_data,
    input  logic [`XLEN-1:`PC_LSB]      i_pc,
    input  logic [`XLEN-1:`PC_LSB]      i_pc_p4,
    output logic [`XLEN-1:`PC_LSB]      o_pc,
    output logic [`XLEN-1:`PC_LSB]      o_pc_p4,
    decode_if.latch                     dec
);

    // flush wins over stall
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            dec.instr <= '0;
            o_pc      <= '0;
            o_pc_p4   <= '0;
        end
        else if (i_flush)
        begin
            dec.instr <= '0;
            o_pc      <= '0;
            o_pc_p4   <= '0;
        end
        else if (!i_stall)
        begin
            dec.instr <= i_data;
            o_pc      <= i_pc;
            o_pc_p4   <= i_pc_p4;
        end
    end

endmodule

//--- decode_if.sv
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

interface decode_if;
    import rv_decode_pkg::*;

    logic [`XLEN-1:0]       instr;
    instr_op_e              op;
    logic [`REG_IDX_W-1:0]  rd;
    logic [`REG_IDX_W-1:0]  rs1;
    logic [`REG_IDX_W-1:0]  rs2;

    // pipeline register side
    modport latch (output instr);

    // classifier fills in the opcode and register indices
    modport cls (input instr, output op, rd, rs1, rs2);

    // back-end decoders only look
    modport user (input instr, op, rd, rs1, rs2);

endinterface

//--- rv_decode_pkg.sv
package rv_decode_pkg;

    // one value per decoded instruction
    typedef enum logic [5:0]
    {
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
        OP_ECALL, OP_EBREAK,
        OP_FENCE, OP_FENCE_I,
        OP_INVALID
    } instr_op_e;

    // low four bits of the ALU control
    typedef enum logic [3:0]
    {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_XOR  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_AND  = 4'd4,
        ALU_SHL  = 4'd5,
        ALU_SHR  = 4'd6,
        ALU_EQ   = 4'd8,
        ALU_NEQ  = 4'd9,
        ALU_LTS  = 4'd10,
        ALU_LTU  = 4'd11,
        ALU_NLTS = 4'd12,
        ALU_NLTU = 4'd13
    } alu_ctrl_e;

    typedef enum logic [1:0]
    {
        RES_ALU   = 2'd0,
        RES_MEM   = 2'd1,
        RES_PC_P4 = 2'd2
    } res_src_e;

    typedef enum logic
    {
        OP1_REG = 1'b0,
        OP1_PC  = 1'b1
    } op1_sel_e;

    typedef enum logic
    {
        OP2_REG = 1'b0,
        OP2_IMM = 1'b1
    } op2_sel_e;

endpackage

//--- rv_decode_defs.svh
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// datapath widths
`define XLEN            32
`define PC_LSB          2
`define REG_IDX_W       5
`define CSR_IDX_W       12
`define ALU_CTRL_W      5
`define FUNCT3_W        3
`define FUNCT7_W        7

// instruction field positions
`define OPG_LSB         2
`define OPG_W           5
`define RD_LSB          7
`define F3_LSB          12
`define RS1_LSB         15
`define RS2_LSB         20
`define F7_LSB          25
`define F12_LSB         20

// low opcode bits of a 32-bit instruction
`define OPC_FULL        2'b11

// major opcode groups, bits 6:2
`define OPG_LOAD        5'b00000
`define OPG_MISC_MEM    5'b00011
`define OPG_OP_IMM      5'b00100
`define OPG_AUIPC       5'b00101
`define OPG_STORE       5'b01000
`define OPG_OP          5'b01100
`define OPG_LUI         5'b01101
`define OPG_BRANCH      5'b11000
`define OPG_JALR        5'b11001
`define OPG_JAL         5'b11011
`define OPG_SYSTEM      5'b11100

// funct7 for sub, sra and srai
`define F7_ALT          7'b0100000

`endif
